// File: files.f
verilog/branchPkg.sv
verilog/operandSnoop.sv
verilog/branchRsLine.sv
verilog/branchRs.sv
verilog/branchUnit.sv
verilog/branchCluster.sv
tb/branchCluster_asserts.sv
tb/branchCluster_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module branchCluster_tb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "STATUS: PASS" sim.log; then
    exit 0
else
    exit 1
fi

// File: tb/branchCluster_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module branchCluster_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        rdy,
    input logic                        dispEn,
    input logic                        full,
    input logic                        flush,
    input logic [branchPkg::slotWidth:0] count,
    input logic                        issueValid
);
    import branchPkg::*;

    // the dispatcher must respect back-pressure
    dispWhileFull: assert property (@(posedge clk) disable iff (rst) dispEn |-> !full)
        else $error("dispatch while the station is full");

    flushEmpties: assert property (@(posedge clk) disable iff (rst)
        (flush && rdy) |=> (count == '0))
        else $error("queue not empty after a flush");

    issueInReset: assert property (@(posedge clk) rst |-> !issueValid)
        else $error("issue valid during reset");

endmodule

bind branchRs branchCluster_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .rdy        (rdy),
    .dispEn     (dispEn),
    .full       (full),
    .flush      (flush),
    .count      (count),
    .issueValid (issue.valid)
);

`default_nettype wire

// File: tb/branchCluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module branchCluster_tb;
    import branchPkg::*;

    localparam int maxWait = 100;
    localparam logic [2:0] kDisp  = 3'd0;
    localparam logic [2:0] kDrain = 3'd1;
    localparam logic [2:0] kStall = 3'd2;
    localparam logic [2:0] kFull  = 3'd3;

    // each table row holds a dispatch with its later broadcast, or a control step
    typedef struct packed {
        logic [2:0]  kind;
        brOp_t       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  tagO;
        logic [3:0]  tagT;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [1:0]  bus;
        logic [7:0]  delay;
        logic        lat;
        logic [31:0] arg;
    } stepT;

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      dispEn;
    logic      full;
    bcast_t    aluBcast;
    bcast_t    lsBcast;
    brAlloc_t  dispData;
    brResult_t result;

    stepT        steps[$];
    logic        expTaken[$];
    logic [31:0] expTarget[$];
    logic [1:0]  expSlot[$];
    int          expDisp[$];
    logic        expLat[$];
    logic        gotTaken[$];
    logic [31:0] gotTarget[$];
    logic [1:0]  gotSlot[$];
    int          gotNeg[$];
    int          dispNeg[$];
    int          schedDue[$];
    logic [1:0]  schedBus[$];
    logic [3:0]  schedTag[$];
    logic [31:0] schedData[$];

    logic [31:0] seed = 32'd8107;
    int          tickNo;
    int          negCount;
    int          cmpIdx;
    logic        lastRdy;
    logic        prevFull;
    brResult_t   prevResult;

    branchCluster u_branchCluster (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .aluBcast (aluBcast),
        .lsBcast  (lsBcast),
        .dispEn   (dispEn),
        .dispData (dispData),
        .full     (full),
        .result   (result)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // signed less-than decided by the sign bits first, Ge and Geu as negations
    function automatic logic refTaken(brOp_t op, logic [31:0] a, logic [31:0] b);
        logic sLt;
        logic uLt;
        uLt = a < b;
        sLt = (a[31] != b[31]) ? a[31] : uLt;
        case (op)
            brEq:    return a == b;
            brNe:    return a != b;
            brLt:    return sLt;
            brGe:    return !sLt;
            brLtu:   return uLt;
            brGeu:   return !uLt;
            default: return 1'b0;
        endcase
    endfunction

    task automatic stopWithError(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic void addDisp(brOp_t op, logic [31:0] a, logic [31:0] b,
                                    logic [3:0] tagO, logic [3:0] tagT, logic [1:0] bus,
                                    int delay, logic lat);
        stepT s;
        s = '0;
        s.kind = kDisp;
        s.op = op;
        s.a = a;
        s.b = b;
        s.tagO = tagO;
        s.tagT = tagT;
        s.imm = lcg();
        s.pc = lcg();
        s.bus = bus;
        s.delay = 8'(delay);
        s.lat = lat;
        steps.push_back(s);
    endfunction

    function automatic void addCtrl(logic [2:0] kind, int arg);
        stepT s;
        s = '0;
        s.kind = kind;
        s.arg = 32'(arg);
        steps.push_back(s);
    endfunction

    // results of entries younger than a taken branch are dropped until the next drain
    function automatic void buildExpected();
        logic       flushing;
        logic [1:0] tail;
        logic       t;
        int         dIdx;
        flushing = 1'b0;
        tail = 2'd0;
        dIdx = 0;
        foreach (steps[i]) begin
            if (steps[i].kind == kDisp) begin
                if (!flushing) begin
                    t = refTaken(steps[i].op, steps[i].a, steps[i].b);
                    expTaken.push_back(t);
                    expTarget.push_back(steps[i].pc + steps[i].imm);
                    expSlot.push_back(tail);
                    expDisp.push_back(dIdx);
                    expLat.push_back(steps[i].lat);
                    flushing = t;
                end
                tail = tail + 2'd1;
                dIdx++;
            end else if (steps[i].kind == kDrain) begin
                if (flushing) begin
                    tail = 2'd0;
                end
                flushing = 1'b0;
                steps[i].arg = 32'(expTaken.size());
            end
        end
    endfunction

    task automatic tick(input logic disp, input brAlloc_t d, input logic rdyVal);
        bcast_t alu;
        bcast_t ls;
        alu = '0;
        ls = '0;
        foreach (schedDue[i]) begin
            if (schedDue[i] == tickNo) begin
                if (schedBus[i] == 2'd1 || schedBus[i] == 2'd3) begin
                    alu = {1'b1, schedTag[i], schedData[i]};
                end
                // on both buses the LS copy carries different data
                if (schedBus[i] == 2'd2) begin
                    ls = {1'b1, schedTag[i], schedData[i]};
                end else if (schedBus[i] == 2'd3) begin
                    ls = {1'b1, schedTag[i], ~schedData[i]};
                end
            end
        end
        @(posedge clk);
        dispEn <= disp;
        dispData <= d;
        aluBcast <= alu;
        lsBcast <= ls;
        rdy <= rdyVal;
        tickNo++;
        @(negedge clk);
    endtask

    task automatic runDispatch(stepT s);
        brAlloc_t d;
        int       waitCnt;
        waitCnt = 0;
        while (full) begin
            tick(1'b0, '0, 1'b1);
            waitCnt++;
            if (waitCnt > maxWait) begin
                stopWithError("timeout: the station stayed full before a dispatch");
            end
        end
        d.op = s.op;
        d.tagO = s.tagO;
        d.tagT = s.tagT;
        // a waiting operand carries stale data that the broadcast must replace
        d.dataO = (s.tagO != tagFree) ? (s.a ^ 32'hdead_beef) : s.a;
        d.dataT = (s.tagT != tagFree) ? (s.b ^ 32'hdead_beef) : s.b;
        d.imm = s.imm;
        d.pc = s.pc;
        if (s.bus != 2'd0) begin
            schedDue.push_back(tickNo + int'(s.delay));
            schedBus.push_back(s.bus);
            schedTag.push_back((s.tagO != tagFree) ? s.tagO : s.tagT);
            schedData.push_back((s.tagO != tagFree) ? s.a : s.b);
        end
        tick(1'b1, d, 1'b1);
    endtask

    task automatic runDrain(int want);
        int waitCnt;
        waitCnt = 0;
        while (gotTaken.size() < want) begin
            tick(1'b0, '0, 1'b1);
            waitCnt++;
            if (waitCnt > maxWait) begin
                stopWithError("timeout: an expected branch result never arrived");
            end
        end
        repeat (6) tick(1'b0, '0, 1'b1);
        assert (gotTaken.size() == want) else
            stopWithError($sformatf("Mismatch at %0t: %0d results, expected %0d",
                                    $time, gotTaken.size(), want));
        for (; cmpIdx < want; cmpIdx++) begin
            assert (gotTaken[cmpIdx] == expTaken[cmpIdx] &&
                    gotTarget[cmpIdx] == expTarget[cmpIdx] &&
                    gotSlot[cmpIdx] == expSlot[cmpIdx]) else
                stopWithError($sformatf("Mismatch at %0t: result %0d got %b/%h/%0d exp %b/%h/%0d",
                    $time, cmpIdx, gotTaken[cmpIdx], gotTarget[cmpIdx], gotSlot[cmpIdx],
                    expTaken[cmpIdx], expTarget[cmpIdx], expSlot[cmpIdx]));
            // sampled one negedge before the capture edge, so two cycles read as three
            if (expLat[cmpIdx]) begin
                assert (gotNeg[cmpIdx] - dispNeg[expDisp[cmpIdx]] == 3) else
                    stopWithError($sformatf("Mismatch at %0t: result %0d has wrong latency",
                                            $time, cmpIdx));
            end
        end
    endtask

    task automatic runFullWait(logic want);
        int waitCnt;
        waitCnt = 0;
        while (full !== want) begin
            tick(1'b0, '0, 1'b1);
            waitCnt++;
            if (waitCnt > maxWait) begin
                stopWithError("timeout: the full flag did not reach its expected level");
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!lastRdy) begin
                assert (result == prevResult && full == prevFull) else
                    stopWithError($sformatf("Mismatch at %0t: state changed during a stall",
                                            $time));
            end
            if (dispEn && !full && rdy) begin
                dispNeg.push_back(negCount);
            end
            if (result.valid && lastRdy) begin
                gotTaken.push_back(result.taken);
                gotTarget.push_back(result.target);
                gotSlot.push_back(result.slot);
                gotNeg.push_back(negCount);
            end
        end
        prevResult = result;
        prevFull = full;
        lastRdy = rdy;
        negCount++;
    end

    function automatic void buildTable();
        logic [31:0] x;
        x = lcg();
        addDisp(brEq, x, x, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brEq, x, x + 1, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brNe, x, x, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brLt, 32'h8000_0000, 32'd1, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brLtu, 32'h8000_0000, 32'd1, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brGe, 32'hffff_ffff, 32'd0, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brGeu, 32'hffff_ffff, 32'd0, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brGe, x, x, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brLtu, x, x, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        addDisp(brNop, 32'd1, 32'd2, 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
        // stall right behind a ready dispatch
        addDisp(brNe, 32'd1, 32'd2, 0, 0, 0, 0, 0);
        addCtrl(kStall, 4);
        addCtrl(kDrain, 0);
        // wake-up over each bus, in the allocation cycle, and on both buses at once
        addDisp(brEq, x, x, 4'd3, 0, 2'd1, 3, 0);
        addCtrl(kDrain, 0);
        addDisp(brLtu, lcg(), lcg(), 0, 4'd5, 2'd2, 2, 0);
        addCtrl(kDrain, 0);
        addDisp(brGe, lcg(), lcg(), 4'd7, 0, 2'd1, 0, 0);
        addCtrl(kDrain, 0);
        addDisp(brEq, x, x, 0, 4'd8, 2'd3, 2, 0);
        addCtrl(kDrain, 0);
        // an older waiting entry holds back younger ready ones
        addDisp(brNe, x, x, 4'd6, 0, 2'd1, 5, 0);
        addDisp(brEq, 32'd1, 32'd2, 0, 0, 0, 0, 0);
        addDisp(brNop, lcg(), lcg(), 0, 0, 0, 0, 0);
        addDisp(brLtu, lcg(), lcg(), 0, 0, 0, 0, 0);
        addCtrl(kDrain, 0);
        // four waiting entries fill the station
        addDisp(brEq, x, x + 1, 4'd1, 0, 2'd1, 16, 0);
        addDisp(brEq, x, x + 2, 4'd2, 0, 2'd1, 17, 0);
        addDisp(brEq, x, x + 3, 4'd3, 0, 2'd1, 18, 0);
        addDisp(brEq, x, x + 4, 4'd4, 0, 2'd1, 19, 0);
        addCtrl(kFull, 1);
        addCtrl(kStall, 5);
        addCtrl(kFull, 0);
        addCtrl(kDrain, 0);
        // taken branch in the middle of the queue
        addDisp(brNe, 32'd1, 32'd1, 0, 0, 0, 0, 0);
        addDisp(brEq, 32'd5, 32'd5, 0, 0, 0, 0, 0);
        addDisp(brNop, 32'd0, 32'd0, 0, 0, 0, 0, 0);
        addDisp(brEq, x, x, 4'd9, 0, 2'd1, 6, 0);
        addCtrl(kDrain, 0);
        addDisp(brGeu, lcg(), lcg(), 0, 0, 0, 0, 1);
        addCtrl(kDrain, 0);
    endfunction

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        dispEn = 1'b0;
        dispData = '0;
        aluBcast = '0;
        lsBcast = '0;
        tickNo = 0;
        negCount = 0;
        cmpIdx = 0;
        lastRdy = 1'b1;
        prevFull = 1'b0;
        prevResult = '0;
        buildTable();
        buildExpected();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        foreach (steps[i]) begin
            case (steps[i].kind)
                kDisp:   runDispatch(steps[i]);
                kDrain:  runDrain(int'(steps[i].arg));
                kStall:  repeat (int'(steps[i].arg)) tick(1'b0, '0, 1'b0);
                default: runFullWait(steps[i].arg[0]);
            endcase
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/branchCluster.sv
`timescale 1ns/1ps
`default_nettype none

module branchCluster (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  branchPkg::bcast_t    aluBcast,
    input  branchPkg::bcast_t    lsBcast,
    input  logic                 dispEn,
    input  branchPkg::brAlloc_t  dispData,
    output logic                 full,
    output branchPkg::brResult_t result
);
    import branchPkg::*;

    brIssue_t issue;
    logic     flush;

    branchRs u_branchRs (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .aluBcast (aluBcast),
        .lsBcast  (lsBcast),
        .dispEn   (dispEn),
        .dispData (dispData),
        .flush    (flush),
        .full     (full),
        .issue    (issue)
    );

    // the unit resolves one branch while the station holds the next ones
    branchUnit u_branchUnit (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .issue  (issue),
        .result (result),
        .flush  (flush)
    );

endmodule

`default_nettype wire

// File: verilog/branchPkg.sv
`default_nettype none

package branchPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 32;
    localparam int tagWidth  = 4;
    localparam int rsSize    = 4;
    localparam int slotWidth = 2;

    // a zero tag means the operand value is already present
    localparam logic [tagWidth-1:0] tagFree = '0;

    // Lt and Ge are signed, Ltu and Geu unsigned
    typedef enum logic [2:0] {
        brNop = 3'd0,
        brEq  = 3'd1,
        brNe  = 3'd2,
        brLt  = 3'd3,
        brGe  = 3'd4,
        brLtu = 3'd5,
        brGeu = 3'd6
    } brOp_t;

    typedef struct packed {
        logic                 valid;
        logic [tagWidth-1:0]  tag;
        logic [dataWidth-1:0] data;
    } bcast_t;

    typedef struct packed {
        brOp_t                op;
        logic [tagWidth-1:0]  tagO;
        logic [tagWidth-1:0]  tagT;
        logic [dataWidth-1:0] dataO;
        logic [dataWidth-1:0] dataT;
        logic [dataWidth-1:0] imm;
        logic [addrWidth-1:0] pc;
    } brAlloc_t;

    typedef struct packed {
        logic                 valid;
        brOp_t                op;
        logic [dataWidth-1:0] operandO;
        logic [dataWidth-1:0] operandT;
        logic [dataWidth-1:0] imm;
        logic [addrWidth-1:0] pc;
        logic [slotWidth-1:0] slot;
    } brIssue_t;

    typedef struct packed {
        logic                 valid;
        logic                 taken;
        logic [addrWidth-1:0] target;
        logic [slotWidth-1:0] slot;
    } brResult_t;

endpackage

`default_nettype wire

// File: verilog/branchRs.sv
`timescale 1ns/1ps
`default_nettype none

module branchRs (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  branchPkg::bcast_t   aluBcast,
    input  branchPkg::bcast_t   lsBcast,
    input  logic                dispEn,
    input  branchPkg::brAlloc_t dispData,
    input  logic                flush,
    output logic                full,
    output branchPkg::brIssue_t issue
);
    import branchPkg::*;

    logic [slotWidth-1:0] head;
    logic [slotWidth-1:0] tail;
    logic [slotWidth:0]   count;

    logic [rsSize-1:0]    allocEn;
    logic [rsSize-1:0]    slotValid;
    logic [rsSize-1:0]    lineReady;
    logic [dataWidth-1:0] lineOperandO [rsSize];
    logic [dataWidth-1:0] lineOperandT [rsSize];
    brOp_t                lineOp [rsSize];
    logic [dataWidth-1:0] lineImm [rsSize];
    logic [addrWidth-1:0] linePc [rsSize];

    logic allocOk;
    logic canIssue;

    assign full     = (count == (slotWidth+1)'(rsSize));
    assign allocOk  = dispEn && !full;
    assign canIssue = lineReady[head];

    // a slot is occupied when its distance from the head is below the count
    always_comb begin
        logic [slotWidth-1:0] offset;
        for (int i = 0; i < rsSize; i++) begin
            offset       = slotWidth'(i) - head;
            slotValid[i] = ({1'b0, offset} < count);
            allocEn[i]   = allocOk && (tail == slotWidth'(i));
        end
    end

    for (genvar g = 0; g < rsSize; g++) begin : gLine
        branchRsLine u_line (
            .clk      (clk),
            .rst      (rst),
            .rdy      (rdy),
            .aluBcast (aluBcast),
            .lsBcast  (lsBcast),
            .allocEn  (allocEn[g]),
            .alloc    (dispData),
            .valid    (slotValid[g]),
            .ready    (lineReady[g]),
            .operandO (lineOperandO[g]),
            .operandT (lineOperandT[g]),
            .op       (lineOp[g]),
            .imm      (lineImm[g]),
            .pc       (linePc[g])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            issue <= '0;
        end else if (rdy) begin
            if (flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
                issue <= '0;
            end else begin
                // the head issues only in order, so a younger ready entry waits
                issue.valid    <= canIssue;
                issue.op       <= lineOp[head];
                issue.operandO <= lineOperandO[head];
                issue.operandT <= lineOperandT[head];
                issue.imm      <= lineImm[head];
                issue.pc       <= linePc[head];
                issue.slot     <= head;
                if (allocOk) begin
                    tail <= tail + 1'b1;
                end
                if (canIssue) begin
                    head <= head + 1'b1;
                end
                case ({allocOk, canIssue})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/branchRsLine.sv
`timescale 1ns/1ps
`default_nettype none

module branchRsLine (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rdy,
    input  branchPkg::bcast_t               aluBcast,
    input  branchPkg::bcast_t               lsBcast,
    input  logic                            allocEn,
    input  branchPkg::brAlloc_t             alloc,
    input  logic                            valid,
    output logic                            ready,
    output logic [branchPkg::dataWidth-1:0] operandO,
    output logic [branchPkg::dataWidth-1:0] operandT,
    output branchPkg::brOp_t                op,
    output logic [branchPkg::dataWidth-1:0] imm,
    output logic [branchPkg::addrWidth-1:0] pc
);
    import branchPkg::*;

    logic [tagWidth-1:0]  tagO;
    logic [tagWidth-1:0]  tagT;
    logic [dataWidth-1:0] dataO;
    logic [dataWidth-1:0] dataT;

    logic [tagWidth-1:0]  tagInO;
    logic [tagWidth-1:0]  tagInT;
    logic [dataWidth-1:0] dataInO;
    logic [dataWidth-1:0] dataInT;
    logic [tagWidth-1:0]  tagNextO;
    logic [tagWidth-1:0]  tagNextT;
    logic [dataWidth-1:0] dataNextO;
    logic [dataWidth-1:0] dataNextT;

    // snooping the incoming operands too catches a broadcast in the allocation cycle
    assign tagInO  = allocEn ? alloc.tagO  : tagO;
    assign tagInT  = allocEn ? alloc.tagT  : tagT;
    assign dataInO = allocEn ? alloc.dataO : dataO;
    assign dataInT = allocEn ? alloc.dataT : dataT;

    operandSnoop u_snoopO (
        .tagNow   (tagInO),
        .dataNow  (dataInO),
        .aluBcast (aluBcast),
        .lsBcast  (lsBcast),
        .tagNext  (tagNextO),
        .dataNext (dataNextO)
    );

    operandSnoop u_snoopT (
        .tagNow   (tagInT),
        .dataNow  (dataInT),
        .aluBcast (aluBcast),
        .lsBcast  (lsBcast),
        .tagNext  (tagNextT),
        .dataNext (dataNextT)
    );

    assign ready    = valid && (tagNextO == tagFree) && (tagNextT == tagFree);
    assign operandO = dataNextO;
    assign operandT = dataNextT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagO <= tagFree;
            tagT <= tagFree;
        end else if (rdy) begin
            tagO <= tagNextO;
            tagT <= tagNextT;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            dataO <= dataNextO;
            dataT <= dataNextT;
            if (allocEn) begin
                op  <= alloc.op;
                imm <= alloc.imm;
                pc  <= alloc.pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  branchPkg::brIssue_t  issue,
    output branchPkg::brResult_t result,
    output logic                 flush
);
    import branchPkg::*;

    logic condTaken;
    logic accept;

    always_comb begin
        case (issue.op)
            brEq:    condTaken = (issue.operandO == issue.operandT);
            brNe:    condTaken = (issue.operandO != issue.operandT);
            brLt:    condTaken = ($signed(issue.operandO) < $signed(issue.operandT));
            brGe:    condTaken = ($signed(issue.operandO) >= $signed(issue.operandT));
            brLtu:   condTaken = (issue.operandO < issue.operandT);
            brGeu:   condTaken = (issue.operandO >= issue.operandT);
            default: condTaken = 1'b0;
        endcase
    end

    // an issue that meets a taken result belongs to the wrong path
    assign accept = issue.valid && !flush;

    // branches are predicted not-taken, so every taken one is a mispredict
    assign flush = result.valid && result.taken;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (rdy) begin
            result.valid  <= accept;
            result.taken  <= accept && condTaken;
            result.target <= issue.pc + issue.imm;
            result.slot   <= issue.slot;
        end
    end

endmodule

`default_nettype wire

// File: verilog/operandSnoop.sv
`timescale 1ns/1ps
`default_nettype none

module operandSnoop (
    input  logic [branchPkg::tagWidth-1:0]  tagNow,
    input  logic [branchPkg::dataWidth-1:0] dataNow,
    input  branchPkg::bcast_t               aluBcast,
    input  branchPkg::bcast_t               lsBcast,
    output logic [branchPkg::tagWidth-1:0]  tagNext,
    output logic [branchPkg::dataWidth-1:0] dataNext
);
    import branchPkg::*;

    logic aluHit;
    logic lsHit;

    // an operand that is already present never matches a broadcast
    assign aluHit = (tagNow != tagFree) && aluBcast.valid && (aluBcast.tag == tagNow);
    assign lsHit  = (tagNow != tagFree) && lsBcast.valid && (lsBcast.tag == tagNow);

    always_comb begin
        tagNext  = tagNow;
        dataNext = dataNow;
        // the ALU bus wins when both buses carry the tag
        if (aluHit) begin
            tagNext  = tagFree;
            dataNext = aluBcast.data;
        end else if (lsHit) begin
            tagNext  = tagFree;
            dataNext = lsBcast.data;
        end
    end

endmodule

`default_nettype wire
